// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_conv_top
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== src/axil_regs.sv ====
module axil_regs
    import conv_cfg_pkg::*;
    import conv_types_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       awvalid,
    output logic                       awready,
    input  logic [AXI_AW-1:0]          awaddr,
    input  logic                       wvalid,
    output logic                       wready,
    input  logic [AXI_DW-1:0]          wdata,
    output logic                       bvalid,
    input  logic                       bready,
    output logic [1:0]                 bresp,
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [AXI_AW-1:0]          araddr,
    output logic                       rvalid,
    input  logic                       rready,
    output logic [AXI_DW-1:0]          rdata,
    output logic [1:0]                 rresp,

    output mem_wr_t                    mem_wr,
    output job_cmd_t                   job,
    input  logic                       busy,

    input  logic signed [RESULT_W-1:0] fifo_head,
    input  logic                       fifo_empty,
    input  logic                       fifo_full,
    input  logic [FIFO_CNT_W-1:0]      fifo_count,
    output logic                       fifo_pop
);

    logic              wr_fire;
    logic              wr_ok;
    logic              rd_fire;
    axi_resp_t         wr_resp;
    axi_resp_t         rd_resp;
    logic [AXI_DW-1:0] rd_word;
    logic [AXI_DW-1:0] status_word;
    logic [AXI_DW-1:0] stage_lo;
    logic [AXI_DW-1:0] stage_hi;
    logic [AXI_DW-1:0] weight;

    assign wr_fire  = awready && awvalid && wvalid;
    assign wr_ok    = wr_fire && (wr_resp == RESP_OKAY);
    assign arready  = !rvalid;
    assign rd_fire  = arvalid && arready;
    assign fifo_pop = rd_fire && (araddr == REG_RESULT) && !fifo_empty;

    // Image commit and job start are refused while the engine runs
    always_comb begin
        case (awaddr)
            REG_CTRL, REG_IMG_ADDR: wr_resp = busy ? RESP_SLVERR : RESP_OKAY;
            REG_IMG_LO, REG_IMG_HI, REG_WEIGHT: wr_resp = RESP_OKAY;
            REG_STATUS, REG_RESULT: wr_resp = RESP_OKAY;
            default: wr_resp = RESP_SLVERR;
        endcase
    end

    always_comb begin
        status_word = '0;
        status_word[0] = busy;
        status_word[1] = fifo_empty;
        status_word[2] = fifo_full;
        status_word[4 +: FIFO_CNT_W] = fifo_count;
    end

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            REG_CTRL, REG_IMG_ADDR: rd_word = '0;
            REG_IMG_LO: rd_word = stage_lo;
            REG_IMG_HI: rd_word = stage_hi;
            REG_WEIGHT: rd_word = weight;
            REG_STATUS: rd_word = status_word;
            REG_RESULT: begin
                if (fifo_empty) begin
                    rd_resp = RESP_SLVERR;
                end else begin
                    rd_word = fifo_head;
                end
            end
            default: rd_resp = RESP_SLVERR;
        endcase
    end

    // Write channel, address and data are taken together
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_resp;
        end
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok && awaddr == REG_IMG_LO) begin
            stage_lo <= wdata;
        end
        if (wr_ok && awaddr == REG_IMG_HI) begin
            stage_hi <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            weight <= '0;
        end else if (wr_ok && awaddr == REG_WEIGHT) begin
            weight <= wdata;
        end
    end

    // One-cycle pulses towards the memory and the engine
    always_ff @(posedge clk) begin
        mem_wr.addr    <= wdata[$bits(mem_wr.addr)-1:0];
        mem_wr.data    <= {stage_hi, stage_lo};
        job.start      <= wdata[$bits(job.start)-1:0];
        job.count_m1   <= wdata[8 +: $bits(job.count_m1)];
        job.weights    <= weight;
        if (rst) begin
            mem_wr.valid <= 1'b0;
            job.valid    <= 1'b0;
        end else begin
            mem_wr.valid <= wr_ok && (awaddr == REG_IMG_ADDR);
            job.valid    <= wr_ok && (awaddr == REG_CTRL);
        end
    end

endmodule

// ==== src/conv_cfg_pkg.sv ====
package conv_cfg_pkg;

    // Image sample and memory geometry
    localparam int IMG_WIDTH_DEF  = 8;
    localparam int DEPTH_NB_DEF   = 8;
    localparam int GROUP_NB_DEF   = 4;
    // Group address, 64 groups over 32 words
    localparam int MEM_AWIDTH_DEF = 6;

    // Result path
    localparam int FIFO_DEPTH_DEF = 4;
    localparam int FIFO_CNT_W     = $clog2(FIFO_DEPTH_DEF + 1);
    localparam int RESULT_W       = 32;

    // AXI4-Lite port widths
    localparam int AXI_AW = 5;
    localparam int AXI_DW = 32;

    // Register map
    localparam logic [AXI_AW-1:0] REG_CTRL     = 5'h00;
    localparam logic [AXI_AW-1:0] REG_IMG_LO   = 5'h04;
    localparam logic [AXI_AW-1:0] REG_IMG_HI   = 5'h08;
    localparam logic [AXI_AW-1:0] REG_IMG_ADDR = 5'h0C;
    localparam logic [AXI_AW-1:0] REG_WEIGHT   = 5'h10;
    localparam logic [AXI_AW-1:0] REG_STATUS   = 5'h14;
    localparam logic [AXI_AW-1:0] REG_RESULT   = 5'h18;

endpackage

// ==== src/conv_top.sv ====
module conv_top
    import conv_cfg_pkg::*;
    import conv_types_pkg::*;
#(
    parameter int DEPTH_NB   = DEPTH_NB_DEF,
    parameter int GROUP_NB   = GROUP_NB_DEF,
    parameter int IMG_WIDTH  = IMG_WIDTH_DEF,
    parameter int MEM_AWIDTH = MEM_AWIDTH_DEF,
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              awvalid,
    output logic              awready,
    input  logic [AXI_AW-1:0] awaddr,
    input  logic              wvalid,
    output logic              wready,
    input  logic [AXI_DW-1:0] wdata,
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    input  logic              arvalid,
    output logic              arready,
    input  logic [AXI_AW-1:0] araddr,
    output logic              rvalid,
    input  logic              rready,
    output logic [AXI_DW-1:0] rdata,
    output logic [1:0]        rresp
);

    mem_wr_t                       mem_wr;
    job_cmd_t                      job;
    mem_rd_req_t                   rd_req;
    logic [GROUP_NB*IMG_WIDTH-1:0] rd_data;
    logic                          rd_data_val;
    logic                          busy;
    logic                          push;
    logic signed [RESULT_W-1:0]    result;
    logic signed [RESULT_W-1:0]    fifo_head;
    logic                          fifo_empty;
    logic                          fifo_full;
    logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count;
    logic                          fifo_pop;

    axil_regs u_regs (
        .clk, .rst,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .mem_wr, .job, .busy,
        .fifo_head, .fifo_empty, .fifo_full, .fifo_count, .fifo_pop
    );

    image_mem #(
        .DEPTH_NB(DEPTH_NB), .GROUP_NB(GROUP_NB),
        .IMG_WIDTH(IMG_WIDTH), .MEM_AWIDTH(MEM_AWIDTH)
    ) u_mem (
        .clk, .rst, .wr(mem_wr), .rd(rd_req), .rd_data, .rd_data_val
    );

    dot_engine #(
        .GROUP_NB(GROUP_NB), .IMG_WIDTH(IMG_WIDTH), .MEM_AWIDTH(MEM_AWIDTH)
    ) u_engine (
        .clk, .rst, .job, .rd(rd_req), .rd_data, .rd_data_val,
        .busy, .push, .result, .fifo_full
    );

    result_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
        .clk, .rst, .push, .din(result), .pop(fifo_pop),
        .head(fifo_head), .empty(fifo_empty), .full(fifo_full), .count(fifo_count)
    );

endmodule

// ==== src/conv_types_pkg.sv ====
package conv_types_pkg;

    import conv_cfg_pkg::*;

    // Word address drops the bank select bits from the group address
    localparam int BANK_LG2_DEF = $clog2(DEPTH_NB_DEF / GROUP_NB_DEF);
    localparam int WORD_AW      = MEM_AWIDTH_DEF - BANK_LG2_DEF;
    localparam int JOB_CNT_W    = MEM_AWIDTH_DEF - 1;

    // One job, count is stored minus one
    typedef struct packed {
        logic                                 valid;
        logic [MEM_AWIDTH_DEF-1:0]            start;
        logic [JOB_CNT_W-1:0]                 count_m1;
        logic [GROUP_NB_DEF*IMG_WIDTH_DEF-1:0] weights;
    } job_cmd_t;

    // Full image word write
    typedef struct packed {
        logic                                 valid;
        logic [WORD_AW-1:0]                   addr;
        logic [DEPTH_NB_DEF*IMG_WIDTH_DEF-1:0] data;
    } mem_wr_t;

    // Group read request
    typedef struct packed {
        logic                      valid;
        logic [MEM_AWIDTH_DEF-1:0] addr;
    } mem_rd_req_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_ISSUE,
        ENG_DRAIN,
        ENG_PUSH
    } engine_state_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

endpackage

// ==== src/dot_engine.sv ====
module dot_engine
    import conv_cfg_pkg::*;
    import conv_types_pkg::*;
#(
    parameter int GROUP_NB   = GROUP_NB_DEF,
    parameter int IMG_WIDTH  = IMG_WIDTH_DEF,
    parameter int MEM_AWIDTH = MEM_AWIDTH_DEF
) (
    input  logic                          clk,
    input  logic                          rst,
    input  job_cmd_t                      job,
    output mem_rd_req_t                   rd,
    input  logic [GROUP_NB*IMG_WIDTH-1:0] rd_data,
    input  logic                          rd_data_val,
    output logic                          busy,
    output logic                          push,
    output logic signed [RESULT_W-1:0]    result,
    input  logic                          fifo_full
);

    localparam int LANE_DW = GROUP_NB * IMG_WIDTH;

    engine_state_t              state;
    logic [MEM_AWIDTH-1:0]      rd_addr;
    logic [JOB_CNT_W-1:0]       issue_left;
    logic [JOB_CNT_W-1:0]       ret_left;
    logic [LANE_DW-1:0]         weights;
    logic signed [RESULT_W-1:0] acc;

    // Lanes are unsigned pixels, weights are signed bytes
    function automatic logic signed [RESULT_W-1:0] group_dot(
        input logic [LANE_DW-1:0] data,
        input logic [LANE_DW-1:0] wts
    );
        logic signed [RESULT_W-1:0]  sum;
        logic signed [IMG_WIDTH:0]   lane;
        logic signed [IMG_WIDTH-1:0] w;
        logic signed [2*IMG_WIDTH:0] prod;
        sum = '0;
        for (int i = 0; i < GROUP_NB; i++) begin
            lane = $signed({1'b0, data[i*IMG_WIDTH +: IMG_WIDTH]});
            w    = $signed(wts[i*IMG_WIDTH +: IMG_WIDTH]);
            prod = lane * w;
            sum  = sum + RESULT_W'(prod);
        end
        return sum;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ENG_IDLE;
        end else begin
            case (state)
                ENG_IDLE:  if (job.valid) state <= ENG_ISSUE;
                ENG_ISSUE: if (issue_left == '0) state <= ENG_DRAIN;
                ENG_DRAIN: if (rd_data_val && ret_left == '0) state <= ENG_PUSH;
                ENG_PUSH:  if (!fifo_full) state <= ENG_IDLE;
                default:   state <= ENG_IDLE;
            endcase
        end
    end

    // Returns can start while reads are still being issued
    always_ff @(posedge clk) begin
        if (state == ENG_IDLE && job.valid) begin
            rd_addr    <= job.start;
            issue_left <= job.count_m1;
            ret_left   <= job.count_m1;
            weights    <= job.weights;
            acc        <= '0;
        end else begin
            if (state == ENG_ISSUE) begin
                rd_addr    <= rd_addr + 1'b1;
                issue_left <= issue_left - 1'b1;
            end
            if (rd_data_val) begin
                ret_left <= ret_left - 1'b1;
                acc      <= acc + group_dot(rd_data, weights);
            end
        end
    end

    always_comb begin
        rd.valid = (state == ENG_ISSUE);
        rd.addr  = rd_addr;
    end

    assign busy   = (state != ENG_IDLE);
    assign push   = (state == ENG_PUSH) && !fifo_full;
    assign result = acc;

endmodule

// ==== src/image_mem.sv ====
module image_mem
    import conv_cfg_pkg::*;
    import conv_types_pkg::*;
#(
    parameter int DEPTH_NB   = DEPTH_NB_DEF,
    parameter int GROUP_NB   = GROUP_NB_DEF,
    parameter int IMG_WIDTH  = IMG_WIDTH_DEF,
    parameter int MEM_AWIDTH = MEM_AWIDTH_DEF
) (
    input  logic                          clk,
    input  logic                          rst,
    input  mem_wr_t                       wr,
    input  mem_rd_req_t                   rd,
    output logic [GROUP_NB*IMG_WIDTH-1:0] rd_data,
    output logic                          rd_data_val
);

    // Bank count must be a power of two, at least two
    localparam int BANK_DW    = GROUP_NB * IMG_WIDTH;
    localparam int BANK_NB    = DEPTH_NB / GROUP_NB;
    localparam int BANK_LG2   = $clog2(BANK_NB);
    localparam int BANK_AW    = MEM_AWIDTH - BANK_LG2;
    localparam int BANK_DEPTH = 1 << BANK_AW;

    logic [DEPTH_NB*IMG_WIDTH-1:0] wr_data_1p;
    logic                          wr_val_1p;
    logic                          rd_val_1p;
    logic                          rd_val_2p;
    logic [BANK_AW-1:0]            addr_1p;
    logic [BANK_LG2-1:0]           mux_1p;
    logic [BANK_LG2-1:0]           mux_2p;
    logic [BANK_DW-1:0]            rd_data_2p [BANK_NB];

    always_ff @(posedge clk) begin
        wr_data_1p <= wr.data;
    end

    // Write wins, a read in the same cycle is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_val_1p   <= 1'b0;
            rd_val_1p   <= 1'b0;
            rd_val_2p   <= 1'b0;
            rd_data_val <= 1'b0;
        end else begin
            wr_val_1p   <= wr.valid;
            rd_val_1p   <= rd.valid && !wr.valid;
            rd_val_2p   <= rd_val_1p;
            rd_data_val <= rd_val_2p;
        end
    end

    // Shared row address for all banks
    always_ff @(posedge clk) begin
        if (wr.valid) begin
            addr_1p <= wr.addr;
        end else if (rd.valid) begin
            addr_1p <= rd.addr[BANK_LG2 +: BANK_AW];
        end
    end

    // Bank select follows the read through the array stage
    always_ff @(posedge clk) begin
        mux_1p <= rd.addr[0 +: BANK_LG2];
        mux_2p <= mux_1p;
    end

    for (genvar b = 0; b < BANK_NB; b++) begin : g_bank
        logic [BANK_DW-1:0] bank [BANK_DEPTH];

        always_ff @(posedge clk) begin
            if (wr_val_1p) begin
                bank[addr_1p] <= wr_data_1p[b*BANK_DW +: BANK_DW];
            end else if (rd_val_1p) begin
                rd_data_2p[b] <= bank[addr_1p];
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= rd_data_2p[mux_2p];
    end

endmodule

// ==== src/result_fifo.sv ====
module result_fifo
    import conv_cfg_pkg::*;
#(
    parameter int DEPTH = FIFO_DEPTH_DEF
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             push,
    input  logic signed [RESULT_W-1:0]       din,
    input  logic                             pop,
    output logic signed [RESULT_W-1:0]       head,
    output logic                             empty,
    output logic                             full,
    output logic [$clog2(DEPTH+1)-1:0]       count
);

    localparam int PTR_W = $clog2(DEPTH);

    logic signed [RESULT_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic                       do_push;
    logic                       do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap at DEPTH so any depth works
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == DEPTH);

endmodule

// ==== tb.f ====
src/conv_cfg_pkg.sv
src/conv_types_pkg.sv
src/axil_regs.sv
src/image_mem.sv
src/dot_engine.sv
src/result_fifo.sv
src/conv_top.sv
tests/tb_conv_top.sv

// ==== tests/tb_conv_top.sv ====
module tb_conv_top
    import conv_cfg_pkg::*;
    import conv_types_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h2dc4;
    // Random, group select, busy rule and back-pressure jobs plus the refused start
    localparam int NUM_JOBS        = 30 + 4 + 3 + 5;
    localparam int WATCHDOG_CYCLES = 200 * NUM_JOBS + 2000;

    logic              clk;
    logic              rst;
    logic              awvalid;
    logic              awready;
    logic [AXI_AW-1:0] awaddr;
    logic              wvalid;
    logic              wready;
    logic [AXI_DW-1:0] wdata;
    logic              bvalid;
    logic              bready;
    logic [1:0]        bresp;
    logic              arvalid;
    logic              arready;
    logic [AXI_AW-1:0] araddr;
    logic              rvalid;
    logic              rready;
    logic [AXI_DW-1:0] rdata;
    logic [1:0]        rresp;

    // Reference model of image memory, weights and expected results
    logic [63:0]                mem_model [32];
    logic [31:0]                weight_model;
    logic signed [RESULT_W-1:0] result_q [$];

    conv_top dut (
        .clk, .rst,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp
    );

    always #10 clk = ~clk;

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the test did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    // Unsigned pixel lanes times signed weight bytes, group address wraps at 64
    function automatic logic signed [RESULT_W-1:0] expected_dot(input int start, input int count);
        int          sum;
        int          addr;
        int          lane;
        int          w;
        logic [63:0] word;
        logic [31:0] grp;
        sum = 0;
        for (int g = 0; g < count; g++) begin
            addr = (start + g) % 64;
            word = mem_model[addr / 2];
            grp  = (addr % 2 == 1) ? word[63:32] : word[31:0];
            for (int i = 0; i < 4; i++) begin
                lane = int'(grp[8*i +: 8]);
                w    = int'($signed(weight_model[8*i +: 8]));
                sum += lane * w;
            end
        end
        return sum;
    endfunction

    function automatic logic [AXI_DW-1:0] status_bits(input logic busy, input logic empty,
                                                      input logic full, input int count);
        logic [AXI_DW-1:0] s;
        s      = '0;
        s[0]   = busy;
        s[1]   = empty;
        s[2]   = full;
        s[6:4] = count[2:0];
        return s;
    endfunction

    task automatic check_result(input logic signed [RESULT_W-1:0] got,
                                input logic signed [RESULT_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_resp(input axi_resp_t got, input axi_resp_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s response %s expected %s",
                     $time, what, got.name(), exp.name());
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_status(input logic [AXI_DW-1:0] got, input logic [AXI_DW-1:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s status %h expected %h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // Called and returning on a falling edge
    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
                             output axi_resp_t resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        if (!wready) begin
            $display("Write data was not accepted together with the write address");
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        while (!bvalid) @(negedge clk);
        resp = axi_resp_t'(bresp);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [AXI_DW-1:0] data,
                            output axi_resp_t resp);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) @(negedge clk);
        data    = rdata;
        resp    = axi_resp_t'(rresp);
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic write_reg(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
                             input axi_resp_t exp, input string what);
        axi_resp_t resp;
        axi_write(addr, data, resp);
        check_resp(resp, exp, what);
    endtask

    task automatic read_status(output logic [AXI_DW-1:0] data);
        axi_resp_t resp;
        axi_read(REG_STATUS, data, resp);
        check_resp(resp, RESP_OKAY, "status read");
    endtask

    task automatic expect_status(input logic busy, input logic empty, input logic full,
                                 input int count, input string what);
        logic [AXI_DW-1:0] data;
        read_status(data);
        check_status(data, status_bits(busy, empty, full, count), what);
    endtask

    task automatic start_job(input int start, input int count);
        logic [AXI_DW-1:0] data;
        data = (32'(count - 1) << 8) | 32'(start);
        write_reg(REG_CTRL, data, RESP_OKAY, "job start");
        result_q.push_back(expected_dot(start, count));
    endtask

    task automatic wait_busy_high();
        logic [AXI_DW-1:0] data;
        read_status(data);
        while (!data[0]) read_status(data);
    endtask

    task automatic wait_busy_low();
        logic [AXI_DW-1:0] data;
        read_status(data);
        while (data[0]) read_status(data);
    endtask

    task automatic pop_check(input string what);
        logic [AXI_DW-1:0] data;
        axi_resp_t         resp;
        axi_read(REG_RESULT, data, resp);
        check_resp(resp, RESP_OKAY, what);
        check_result($signed(data), result_q.pop_front(), what);
    endtask

    task automatic run_and_check(input int start, input int count, input string what);
        start_job(start, count);
        wait_busy_high();
        wait_busy_low();
        pop_check(what);
    endtask

    initial begin : main
        logic [31:0]       lo;
        logic [31:0]       hi;
        logic [AXI_DW-1:0] data;
        axi_resp_t         resp;
        int                tgt;
        int                start;
        int                count;
        clk     = 1'b0;
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        void'($urandom(SEED));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        expect_status(1'b0, 1'b1, 1'b0, 0, "after reset");
        axi_read(REG_RESULT, data, resp);
        check_resp(resp, RESP_SLVERR, "pop of empty FIFO");
        check_result($signed(data), '0, "data of empty pop");

        // Whole image and one weight word
        for (int w = 0; w < 32; w++) begin
            lo = $urandom;
            hi = $urandom;
            write_reg(REG_IMG_LO, lo, RESP_OKAY, "staging low");
            write_reg(REG_IMG_HI, hi, RESP_OKAY, "staging high");
            write_reg(REG_IMG_ADDR, 32'(w), RESP_OKAY, "image commit");
            mem_model[w] = {hi, lo};
        end
        weight_model = $urandom;
        write_reg(REG_WEIGHT, weight_model, RESP_OKAY, "weight write");

        // First jobs always wrap past group 63
        for (int j = 0; j < 30; j++) begin
            start = (j < 3) ? 60 + j : int'($urandom % 64);
            count = (j < 3) ? 10 + j : int'($urandom % 32) + 1;
            run_and_check(start, count, "random job");
        end

        for (int k = 0; k < 2; k++) begin
            tgt = $urandom % 32;
            run_and_check(2 * tgt, 1, "even group");
            run_and_check(2 * tgt + 1, 1, "odd group");
        end

        // Commit and start refused during a long job
        tgt = $urandom % 32;
        write_reg(REG_IMG_LO, ~mem_model[tgt][31:0], RESP_OKAY, "staging low");
        write_reg(REG_IMG_HI, ~mem_model[tgt][63:32], RESP_OKAY, "staging high");
        start_job(0, 32);
        wait_busy_high();
        write_reg(REG_IMG_ADDR, 32'(tgt), RESP_SLVERR, "commit while busy");
        write_reg(REG_CTRL, 32'h0000_0105, RESP_SLVERR, "start while busy");
        wait_busy_low();
        expect_status(1'b0, 1'b0, 1'b0, 1, "after refused writes");
        pop_check("long job");
        run_and_check(2 * tgt, 2, "image readback");

        // Fill the FIFO, the fifth job has to wait for a pop
        for (int j = 0; j < 4; j++) begin
            start_job($urandom % 64, ($urandom % 32) + 1);
            wait_busy_high();
            wait_busy_low();
        end
        expect_status(1'b0, 1'b0, 1'b1, 4, "FIFO full");
        start = int'($urandom % 64);
        count = int'($urandom % 32) + 1;
        start_job(start, count);
        wait_busy_high();
        // Longer than the job takes with a free FIFO
        repeat (count + 4) @(negedge clk);
        expect_status(1'b1, 1'b0, 1'b1, 4, "engine held by full FIFO");
        pop_check("back-pressure result 0");
        wait_busy_low();
        for (int j = 1; j < 5; j++) begin
            pop_check($sformatf("back-pressure result %0d", j));
        end
        expect_status(1'b0, 1'b1, 1'b0, 0, "FIFO drained");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
